// ==== verilog/kiwi_snd_pkg.sv ====
/* Memory map and register numbering of the sound board.
   Address bits 15:12 pick the region; everything below 0xA000 is ROM. */
package kiwi_snd_pkg;

    // Registered decode result of one CPU access
    typedef enum logic [2:0] {
        RGN_NONE,
        RGN_ROM,
        RGN_BANK,
        RGN_PSG,
        RGN_CAB,
        RGN_RAM,
        RGN_MIX
    } snd_region_e;

    // Values of address bits 15:12
    localparam logic [3:0] NIB_ROM_TOP = 4'ha; // ROM sits below this
    localparam logic [3:0] NIB_BANK    = 4'ha;
    localparam logic [3:0] NIB_PSG     = 4'hb;
    localparam logic [3:0] NIB_CAB     = 4'hc;
    localparam logic [3:0] NIB_RAM0    = 4'hd;
    localparam logic [3:0] NIB_RAM1    = 4'he;
    localparam logic [3:0] NIB_MIX     = 4'hf;

    localparam int DEV_AW = 3; // Device sub-address bits
    localparam int RAM_AW = 13;

    // Tone chip register indexes
    localparam logic [3:0] PSG_PER_A_LO = 4'd0;
    localparam logic [3:0] PSG_PER_A_HI = 4'd1;
    localparam logic [3:0] PSG_PER_B_LO = 4'd2;
    localparam logic [3:0] PSG_PER_B_HI = 4'd3;
    localparam logic [3:0] PSG_VOL_A    = 4'd8;
    localparam logic [3:0] PSG_VOL_B    = 4'd9;
    localparam logic [3:0] PSG_DIP_A    = 4'd14;
    localparam logic [3:0] PSG_DIP_B    = 4'd15;

    typedef logic signed [7:0] amp_t; // Channel level

endpackage

// ==== verilog/snd_dev_if.sv ====
/* One decoded device access from the bus controller.
   There is no handshake, so a write repeats on every clock while wr is high. */
`timescale 1ns/1ps

interface snd_dev_if import kiwi_snd_pkg::*; ();

    logic              cs;    // Registered select of this device
    logic [DEV_AW-1:0] addr;  // Low CPU address bits
    logic [7:0]        wdata;
    logic              wr;    // cs and CPU write
    logic [7:0]        rdata;

    modport ctrl (
        output cs,
        output addr,
        output wdata,
        output wr,
        input  rdata
    );

    modport dev (
        input  cs,
        input  addr,
        input  wdata,
        input  wr,
        output rdata
    );

endinterface

// ==== verilog/snd_bus_ctrl.sv ====
/* Sound CPU bus decoder. Selects come one clock after a stable address and
   read data one more clock later; the IRQ is cleared by any iorq cycle. */
`timescale 1ns/1ps

module snd_bus_ctrl import kiwi_snd_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              vblank_n,
    // CPU side
    input  logic [15:0]       addr,
    input  logic [7:0]        cpu_dout,
    input  logic              mreq,
    input  logic              rd,
    input  logic              wr,
    input  logic              iorq,
    output logic [7:0]        cpu_din,
    output logic              wait_n,
    output logic              int_n,
    // ROM
    output logic              rom_cs,
    input  logic              rom_ok,
    input  logic [7:0]        rom_data,
    // Work RAM
    output logic [RAM_AW-1:0] ram_addr,
    output logic [7:0]        ram_din,
    output logic              ram_we,
    input  logic [7:0]        ram_dout,
    // Devices
    snd_dev_if.ctrl           bank_bus,
    snd_dev_if.ctrl           cab_bus,
    snd_dev_if.ctrl           psg_bus,
    snd_dev_if.ctrl           mix_bus
);

    snd_region_e region;
    logic        vbl_s, vbl_d;

    function automatic snd_region_e decode(input logic [3:0] nib);
        if (nib < NIB_ROM_TOP) begin
            return RGN_ROM;
        end
        case (nib)
            NIB_BANK:           return RGN_BANK;
            NIB_PSG:            return RGN_PSG;
            NIB_CAB:            return RGN_CAB;
            NIB_RAM0, NIB_RAM1: return RGN_RAM;
            NIB_MIX:            return RGN_MIX;
            default:            return RGN_NONE;
        endcase
    endfunction

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            region <= RGN_NONE;
        end else begin
            region <= mreq ? decode(addr[15:12]) : RGN_NONE;
        end
    end

    assign rom_cs = region == RGN_ROM;
    assign wait_n = !(rom_cs && !rom_ok); // Stretch the cycle until ROM data lands

    assign ram_addr = addr[RAM_AW-1:0];
    assign ram_din  = cpu_dout;
    assign ram_we   = region == RGN_RAM && wr;

    // Device buses
    assign bank_bus.cs    = region == RGN_BANK;
    assign bank_bus.addr  = addr[DEV_AW-1:0];
    assign bank_bus.wdata = cpu_dout;
    assign bank_bus.wr    = bank_bus.cs && wr;

    assign cab_bus.cs     = region == RGN_CAB;
    assign cab_bus.addr   = addr[DEV_AW-1:0];
    assign cab_bus.wdata  = cpu_dout;
    assign cab_bus.wr     = cab_bus.cs && wr;

    assign psg_bus.cs     = region == RGN_PSG;
    assign psg_bus.addr   = addr[DEV_AW-1:0];
    assign psg_bus.wdata  = cpu_dout;
    assign psg_bus.wr     = psg_bus.cs && wr;

    assign mix_bus.cs     = region == RGN_MIX;
    assign mix_bus.addr   = addr[DEV_AW-1:0];
    assign mix_bus.wdata  = cpu_dout;
    assign mix_bus.wr     = mix_bus.cs && wr;

    // Read data, held between reads
    always_ff @(posedge clk) begin
        if (rd) begin
            case (region)
                RGN_ROM:  cpu_din <= rom_data;
                RGN_RAM:  cpu_din <= ram_dout;
                RGN_BANK: cpu_din <= bank_bus.rdata;
                RGN_PSG:  cpu_din <= psg_bus.rdata;
                RGN_CAB:  cpu_din <= cab_bus.rdata;
                RGN_MIX:  cpu_din <= mix_bus.rdata;
                default:  cpu_din <= 8'hff; // Open bus
            endcase
        end
    end

    // Vertical blank interrupt
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            vbl_s <= 1'b1;
            vbl_d <= 1'b1;
            int_n <= 1'b1;
        end else begin
            vbl_s <= vblank_n;
            vbl_d <= vbl_s;
            if (iorq) begin
                int_n <= 1'b1; // No m1 check, same as the PCB
            end else if (vbl_d && !vbl_s) begin
                int_n <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/snd_rom_bank.sv ====
/* ROM bank latch. Only the upper 32 kB window is banked,
   bits 14:13 come from the latch there. */
`timescale 1ns/1ps

module snd_rom_bank (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] addr,
    output logic [15:0] rom_addr,
    output logic        mcu_rst,
    snd_dev_if.dev      bus
);

    logic [1:0] bank;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bank    <= 2'd0;
            mcu_rst <= 1'b0;
        end else if (bus.wr) begin
            bank    <= bus.wdata[1:0];
            mcu_rst <= bus.wdata[2]; // Holds the companion MCU in reset
        end
    end

    assign bus.rdata = {5'h1f, mcu_rst, bank};

    always_comb begin
        rom_addr = addr;
        if (addr[15]) begin
            rom_addr[14:13] = bank; // Banked window
        end
    end

endmodule

// ==== verilog/cab_inputs.sv ====
/* Cabinet input ports, sampled every clock from the sub-address.
   Tilt is not wired and reads as 1. */
`timescale 1ns/1ps

module cab_inputs (
    input  logic       clk,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic [6:0] joystick1,
    input  logic [6:0] joystick2,
    input  logic       service,
    snd_dev_if.dev     bus
);

    logic [7:0] port_q;

    always_ff @(posedge clk) begin
        case (bus.addr)
            3'd0:    port_q <= {start_button[0], joystick1};
            3'd1:    port_q <= {start_button[1], joystick2};
            3'd2:    port_q <= {4'hf, coin_input, 1'b1, service}; // Tilt high
            default: port_q <= 8'hff;
        endcase
    end

    assign bus.rdata = port_q;

endmodule

// ==== verilog/snd_psg.sv ====
/* Two square channels standing in for the PSG part of the sound chip.
   Index/data access as on the real chip; a zero period gives a DC level. */
`timescale 1ns/1ps

module snd_psg import kiwi_snd_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen_snd,
    input  logic [15:0] dipsw,
    snd_dev_if.dev      bus,
    output amp_t        ch_a,
    output amp_t        ch_b
);

    logic [3:0]  index;
    logic [11:0] period [2];
    logic [3:0]  vol [2];
    amp_t        amp [2];
    logic [7:0]  reg_rd;

    // CPU writes
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            index     <= 4'd0;
            period[0] <= 12'd0;
            period[1] <= 12'd0;
            vol[0]    <= 4'd0;
            vol[1]    <= 4'd0;
        end else if (bus.wr) begin
            if (!bus.addr[0]) begin
                index <= bus.wdata[3:0];
            end else begin
                case (index)
                    PSG_PER_A_LO: period[0][7:0]  <= bus.wdata;
                    PSG_PER_A_HI: period[0][11:8] <= bus.wdata[3:0];
                    PSG_PER_B_LO: period[1][7:0]  <= bus.wdata;
                    PSG_PER_B_HI: period[1][11:8] <= bus.wdata[3:0];
                    PSG_VOL_A:    vol[0]          <= bus.wdata[3:0];
                    PSG_VOL_B:    vol[1]          <= bus.wdata[3:0];
                    default:      ;                 // Read-only or unused
                endcase
            end
        end
    end

    always_comb begin
        case (index)
            PSG_PER_A_LO: reg_rd = period[0][7:0];
            PSG_PER_A_HI: reg_rd = {4'h0, period[0][11:8]};
            PSG_PER_B_LO: reg_rd = period[1][7:0];
            PSG_PER_B_HI: reg_rd = {4'h0, period[1][11:8]};
            PSG_VOL_A:    reg_rd = {4'h0, vol[0]};
            PSG_VOL_B:    reg_rd = {4'h0, vol[1]};
            PSG_DIP_A:    reg_rd = dipsw[7:0];
            PSG_DIP_B:    reg_rd = dipsw[15:8];
            default:      reg_rd = 8'hff;
        endcase
    end

    assign bus.rdata = bus.addr[0] ? reg_rd : {4'h0, index};

    for (genvar i = 0; i < 2; i++) begin : g_chan
        logic [11:0] cnt;
        logic        ph;
        amp_t        mag;

        always_ff @(posedge clk, posedge rst) begin
            if (rst) begin
                cnt <= 12'd0;
                ph  <= 1'b1;
            end else if (cen_snd) begin
                if (period[i] == 12'd0) begin
                    cnt <= 12'd0;
                    ph  <= 1'b1;  // DC at +volume
                end else if (cnt >= period[i] - 12'd1) begin
                    cnt <= 12'd0;
                    ph  <= ~ph;
                end else begin
                    cnt <= cnt + 12'd1;
                end
            end
        end

        assign mag    = amp_t'({1'b0, vol[i], 3'b000}); // Volume times 8
        assign amp[i] = ph ? mag : -mag;
    end

    assign ch_a = amp[0];
    assign ch_b = amp[1];

endmodule

// ==== verilog/snd_mixer.sv ====
/* Two-channel mixer with CPU gains, 8-bit unsigned each.
   The sum saturates to 16 bits and peak marks a clipped sample. */
`timescale 1ns/1ps

module snd_mixer import kiwi_snd_pkg::*; #(
    parameter logic [7:0] GAIN0_INIT = 8'h10,
    parameter logic [7:0] GAIN1_INIT = 8'h10
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen_snd,
    input  amp_t               ch_a,
    input  amp_t               ch_b,
    snd_dev_if.dev             bus,
    output logic signed [15:0] snd,
    output logic               sample,
    output logic               peak
);

    logic [7:0]         gain0, gain1;
    logic signed [17:0] mix_sum;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            gain0 <= GAIN0_INIT;
            gain1 <= GAIN1_INIT;
        end else if (bus.wr) begin
            if (bus.addr == DEV_AW'(0)) gain0 <= bus.wdata;
            if (bus.addr == DEV_AW'(1)) gain1 <= bus.wdata;
        end
    end

    assign bus.rdata = bus.addr == DEV_AW'(0) ? gain0 :
                       bus.addr == DEV_AW'(1) ? gain1 : 8'hff;

    // Gains taken as unsigned
    assign mix_sum = ch_a * $signed({1'b0, gain0}) + ch_b * $signed({1'b0, gain1});

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            snd    <= 16'sd0;
            peak   <= 1'b0;
            sample <= 1'b0;
        end else begin
            sample <= cen_snd;
            if (cen_snd) begin
                if (mix_sum > 18'sd32767) begin
                    snd  <= 16'sh7fff;
                    peak <= 1'b1;
                end else if (mix_sum < -18'sd32768) begin
                    snd  <= 16'sh8000;
                    peak <= 1'b1;
                end else begin
                    snd  <= mix_sum[15:0];
                    peak <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== verilog/kiwi_snd_top.sv ====
/* Sound board seen from the Z80 bus; the CPU itself lives outside.
   Level-sensitive, active-high bus strobes, wait_n ends each ROM read. */
`timescale 1ns/1ps

module kiwi_snd_top import kiwi_snd_pkg::*; #(
    parameter logic [7:0] GAIN_FM  = 8'h10,
    parameter logic [7:0] GAIN_PSG = 8'h10
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen_snd,
    input  logic               vblank_n,
    // CPU bus
    input  logic [15:0]        addr,
    input  logic [7:0]         cpu_dout,
    input  logic               mreq,
    input  logic               rd,
    input  logic               wr,
    input  logic               iorq,
    output logic [7:0]         cpu_din,
    output logic               wait_n,
    output logic               int_n,
    // ROM
    output logic [15:0]        rom_addr,
    output logic               rom_cs,
    input  logic               rom_ok,
    input  logic [7:0]         rom_data,
    // RAM
    output logic [RAM_AW-1:0]  ram_addr,
    output logic [7:0]         ram_din,
    output logic               ram_we,
    input  logic [7:0]         ram_dout,
    // Cabinet
    input  logic [1:0]         start_button,
    input  logic [1:0]         coin_input,
    input  logic [6:0]         joystick1,
    input  logic [6:0]         joystick2,
    input  logic               service,
    input  logic [15:0]        dipsw,
    // Sound and MCU
    output logic signed [15:0] snd,
    output logic               sample,
    output logic               peak,
    output logic               mcu_rst
);

    amp_t ch_a, ch_b;

    snd_dev_if bank_if ();
    snd_dev_if cab_if ();
    snd_dev_if psg_if ();
    snd_dev_if mix_if ();

    snd_bus_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .vblank_n (vblank_n),
        .addr     (addr),
        .cpu_dout (cpu_dout),
        .mreq     (mreq),
        .rd       (rd),
        .wr       (wr),
        .iorq     (iorq),
        .cpu_din  (cpu_din),
        .wait_n   (wait_n),
        .int_n    (int_n),
        .rom_cs   (rom_cs),
        .rom_ok   (rom_ok),
        .rom_data (rom_data),
        .ram_addr (ram_addr),
        .ram_din  (ram_din),
        .ram_we   (ram_we),
        .ram_dout (ram_dout),
        .bank_bus (bank_if.ctrl),
        .cab_bus  (cab_if.ctrl),
        .psg_bus  (psg_if.ctrl),
        .mix_bus  (mix_if.ctrl)
    );

    snd_rom_bank u_bank (
        .clk      (clk),
        .rst      (rst),
        .addr     (addr),
        .rom_addr (rom_addr),
        .mcu_rst  (mcu_rst),
        .bus      (bank_if.dev)
    );

    cab_inputs u_cab (
        .clk          (clk),
        .start_button (start_button),
        .coin_input   (coin_input),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .service      (service),
        .bus          (cab_if.dev)
    );

    snd_psg u_psg (
        .clk     (clk),
        .rst     (rst),
        .cen_snd (cen_snd),
        .dipsw   (dipsw),
        .bus     (psg_if.dev),
        .ch_a    (ch_a),
        .ch_b    (ch_b)
    );

    // Gain 0 takes the FM slot of the original board
    snd_mixer #(
        .GAIN0_INIT (GAIN_FM),
        .GAIN1_INIT (GAIN_PSG)
    ) u_mixer (
        .clk     (clk),
        .rst     (rst),
        .cen_snd (cen_snd),
        .ch_a    (ch_a),
        .ch_b    (ch_b),
        .bus     (mix_if.dev),
        .snd     (snd),
        .sample  (sample),
        .peak    (peak)
    );

endmodule

// ==== bench/kiwi_snd_chk.sv ====
/* Bus rules of the sound board, bound into kiwi_snd_top.
   The IRQ rule assumes vblank_n does not fall during an acknowledge. */
`timescale 1ns/1ps

module kiwi_snd_chk (
    input logic clk,
    input logic rst,
    input logic rom_cs,
    input logic ram_we,
    input logic iorq,
    input logic int_n,
    input logic wait_n
);

    // One memory select at a time
    a_ram_rom: assert property (@(posedge clk) disable iff (rst) !(ram_we && rom_cs))
        else $error("ram_we high together with rom_cs");

    a_int_ack: assert property (@(posedge clk) disable iff (rst) iorq |=> int_n)
        else $error("int_n still low after iorq"); // Cleared on the following clock

    // Only a ROM access may stretch the cycle
    a_wait_rom: assert property (@(posedge clk) disable iff (rst) !rom_cs |-> wait_n)
        else $error("wait_n low without a ROM access");

endmodule

bind kiwi_snd_top kiwi_snd_chk u_chk (
    .clk    (clk),
    .rst    (rst),
    .rom_cs (rom_cs),
    .ram_we (ram_we),
    .iorq   (iorq),
    .int_n  (int_n),
    .wait_n (wait_n)
);

// ==== bench/kiwi_snd_tb.sv ====
/* Directed testbench playing the sound CPU. Bus levels change on rising edges
   and are sampled on falling edges; the ROM model answers after 0 to 5 clocks. */
`timescale 1ns/1ps

module kiwi_snd_tb import kiwi_snd_pkg::*; ();

    localparam int WAIT_LIMIT = 20; // Clocks before a wait loop gives up

    logic               clk, rst, cen_snd, vblank_n;
    logic [15:0]        addr;
    logic [7:0]         cpu_dout, cpu_din;
    logic               mreq, rd, wr, iorq, wait_n, int_n;
    logic [15:0]        rom_addr;
    logic               rom_cs, rom_ok;
    logic [7:0]         rom_data;
    logic [RAM_AW-1:0]  ram_addr;
    logic [7:0]         ram_din, ram_dout;
    logic               ram_we;
    logic [1:0]         start_button, coin_input;
    logic [6:0]         joystick1, joystick2;
    logic               service;
    logic [15:0]        dipsw;
    logic signed [15:0] snd;
    logic               sample, peak, mcu_rst;

    logic [7:0] ram_mem [2**RAM_AW];
    int         rom_cnt, rom_dly, cen_cnt;
    int         errors, tests, failed;
    logic       timed_out;
    logic [2:0] bank_val; // Last value written to the bank latch

    kiwi_snd_top i_kiwi_snd_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ROM model, data shows up once the random delay has run out
    always @(posedge clk, posedge rst) begin
        if (rst || !rom_cs) begin
            rom_cnt <= 0;
        end else begin
            rom_cnt <= rom_cnt + 1;
        end
    end
    assign rom_ok   = rom_cs && rom_cnt >= rom_dly;
    assign rom_data = rom_ok ? rom_addr[7:0] ^ 8'h5a : 8'h00;

    always @(posedge clk) begin
        if (ram_we) begin
            ram_mem[ram_addr] <= ram_din;
        end
    end
    assign ram_dout = ram_mem[ram_addr]; // Asynchronous read

    always @(posedge clk, posedge rst) begin
        if (rst) begin
            cen_cnt <= 0;
            cen_snd <= 1'b0;
        end else begin
            cen_cnt <= (cen_cnt + 1) % 4;
            cen_snd <= cen_cnt == 3; // One clock in four
        end
    end

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] exp);
        $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR: %s, gave up after %0d clocks", what, WAIT_LIMIT);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic end_test(input string name, input int first_err);
        tests++;
        if (errors == first_err) begin
            $display("%s: passed", name);
        end else begin
            failed++;
            $display("%s: failed with %0d errors", name, errors - first_err);
        end
    endtask

    task automatic wait_ready(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!wait_n && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!wait_n) begin
            report_timeout({"wait_n stayed low during ", what});
        end
    endtask

    task automatic release_bus();
        @(posedge clk);
        mreq <= 1'b0;
        rd   <= 1'b0;
        wr   <= 1'b0;
        iorq <= 1'b0;
        @(posedge clk); // Select drops here
    endtask

    task automatic cpu_read(input logic [15:0] a, output logic [7:0] data);
        @(posedge clk);
        addr <= a;
        mreq <= 1'b1;
        rd   <= 1'b1;
        @(posedge clk);
        wait_ready("a read");
        @(negedge clk); // cpu_din loaded on the edge in between
        data = cpu_din;
        release_bus();
    endtask

    task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
        @(posedge clk);
        addr     <= a;
        cpu_dout <= d;
        mreq     <= 1'b1;
        wr       <= 1'b1;
        @(posedge clk);
        wait_ready("a write");
        release_bus(); // Write lands on the first edge of the release
    endtask

    task automatic cpu_ack();
        @(posedge clk);
        iorq <= 1'b1;
        wait_ready("an acknowledge");
        release_bus();
    endtask

    task automatic psg_write(input logic [3:0] idx, input logic [7:0] d);
        cpu_write(16'hb000, {4'h0, idx});
        cpu_write(16'hb001, d);
    endtask

    task automatic psg_read(input logic [3:0] idx, output logic [7:0] data);
        cpu_write(16'hb000, {4'h0, idx});
        cpu_read(16'hb001, data);
    endtask

    task automatic wait_samples(input int count);
        int i, n;
        for (i = 0; i < count; i++) begin
            n = 0;
            @(negedge clk);
            while (!sample && n < WAIT_LIMIT) begin
                @(negedge clk);
                n++;
            end
            if (!sample) begin
                report_timeout("waiting for a sample pulse");
            end
        end
    endtask

    function automatic logic signed [15:0] sat16(input int s);
        if (s > 32767) begin
            return 16'sh7fff;
        end
        if (s < -32768) begin
            return 16'sh8000;
        end
        return 16'(s);
    endfunction

    task automatic rom_banking();
        int          first, i;
        logic [15:0] a, exp_addr;
        logic [7:0]  data;
        first    = errors;
        bank_val = {1'b1, 2'(1 + $urandom % 3)}; // Nonzero bank, MCU held in reset
        cpu_write(16'ha000, {5'h00, bank_val});
        @(negedge clk);
        if (mcu_rst !== 1'b1) report_mismatch("mcu_rst", 16'(mcu_rst), 16'h1);
        cpu_read(16'ha000, data);
        if (data !== {5'h1f, bank_val}) report_mismatch("cpu_din", 16'(data), 16'({5'h1f, bank_val}));
        for (i = 0; i < 8; i++) begin
            a        = i[0] ? 16'(32'h8000 + $urandom % 32'h2000) : 16'($urandom % 32'h8000);
            rom_dly  = $urandom % 6;
            exp_addr = a[15] ? {a[15], bank_val[1:0], a[12:0]} : a;
            cpu_read(a, data);
            @(negedge clk);
            if (rom_addr !== exp_addr) report_mismatch("rom_addr", rom_addr, exp_addr);
            if (data !== (a[7:0] ^ 8'h5a)) report_mismatch("cpu_din", 16'(data), 16'(a[7:0] ^ 8'h5a));
            if (rom_cs !== 1'b0) report_mismatch("rom_cs", 16'(rom_cs), 16'h0);
        end
        rom_dly = 0;
        end_test("rom_banking", first);
    endtask

    task automatic ram_access();
        int          first, i;
        logic [15:0] a [8];
        logic [7:0]  d [8];
        logic [7:0]  data;
        first = errors;
        for (i = 0; i < 8; i++) begin
            a[i] = 16'(32'hd000 + i * 32'h400 + $urandom % 32'h400); // One per 1 kB slice
            d[i] = 8'($urandom);
            cpu_write(a[i], d[i]);
            @(negedge clk);
            if (ram_addr !== a[i][12:0]) report_mismatch("ram_addr", 16'(ram_addr), 16'(a[i][12:0]));
            if (ram_din !== d[i]) report_mismatch("ram_din", 16'(ram_din), 16'(d[i]));
            if (ram_we !== 1'b0) report_mismatch("ram_we", 16'(ram_we), 16'h0);
        end
        for (i = 0; i < 8; i++) begin
            cpu_read(a[i], data);
            if (data !== d[i]) report_mismatch("cpu_din", 16'(data), 16'(d[i]));
        end
        cpu_read(16'ha000, data); // Bank must survive the RAM traffic
        if (data !== {5'h1f, bank_val}) report_mismatch("cpu_din", 16'(data), 16'({5'h1f, bank_val}));
        end_test("ram_access", first);
    endtask

    task automatic cabinet_reads();
        int          first, i;
        logic [1:0]  st, cn;
        logic [6:0]  j1, j2;
        logic        sv;
        logic [15:0] dw;
        logic [7:0]  data, exp_port [4];
        first = errors;
        st    = 2'($urandom);
        cn    = 2'($urandom);
        j1    = 7'($urandom);
        j2    = 7'($urandom);
        sv    = 1'($urandom);
        dw    = 16'($urandom);
        @(posedge clk);
        start_button <= st;
        coin_input   <= cn;
        joystick1    <= j1;
        joystick2    <= j2;
        service      <= sv;
        dipsw        <= dw;
        exp_port[0] = {st[0], j1};
        exp_port[1] = {st[1], j2};
        exp_port[2] = {4'hf, cn, 1'b1, sv}; // Tilt reads high
        exp_port[3] = 8'hff;
        for (i = 0; i < 4; i++) begin
            cpu_read(16'hc000 + 16'(i), data);
            if (data !== exp_port[i]) report_mismatch("cpu_din", 16'(data), 16'(exp_port[i]));
        end
        psg_read(PSG_DIP_A, data);
        if (data !== dw[7:0]) report_mismatch("cpu_din", 16'(data), 16'(dw[7:0]));
        psg_read(PSG_DIP_B, data);
        if (data !== dw[15:8]) report_mismatch("cpu_din", 16'(data), 16'(dw[15:8]));
        end_test("cabinet_reads", first);
    endtask

    task automatic vblank_irq();
        int         first, n;
        logic [7:0] data;
        first = errors;
        @(posedge clk);
        vblank_n <= 1'b0;
        n = 0;
        @(negedge clk);
        while (int_n && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (int_n) report_timeout("waiting for int_n to fall after vblank_n");
        repeat (10) begin
            @(negedge clk);
            if (int_n !== 1'b0) report_mismatch("int_n", 16'(int_n), 16'h0);
        end
        cpu_ack();
        @(negedge clk);
        if (int_n !== 1'b1) report_mismatch("int_n", 16'(int_n), 16'h1);
        @(posedge clk);
        vblank_n <= 1'b1;
        // Holes in the device maps read as open bus
        cpu_read(16'hf002, data);
        if (data !== 8'hff) report_mismatch("cpu_din", 16'(data), 16'hff);
        psg_read(4'd5, data);
        if (data !== 8'hff) report_mismatch("cpu_din", 16'(data), 16'hff);
        cpu_read(16'hc007, data);
        if (data !== 8'hff) report_mismatch("cpu_din", 16'(data), 16'hff);
        end_test("vblank_irq", first);
    endtask

    task automatic mixer_gains();
        int                 first, va, vb, ga, gb, s;
        logic [7:0]         data;
        logic signed [15:0] exp_snd;
        logic               exp_peak;
        first = errors;
        psg_write(PSG_PER_A_LO, 8'h00); // Zero periods give a steady +volume
        psg_write(PSG_PER_A_HI, 8'h00);
        psg_write(PSG_PER_B_LO, 8'h00);
        psg_write(PSG_PER_B_HI, 8'h00);
        va = $urandom % 16;
        vb = $urandom % 16;
        ga = $urandom % 128; // Keeps the sum inside 16 bits
        gb = $urandom % 128;
        psg_write(PSG_VOL_A, 8'(va));
        psg_write(PSG_VOL_B, 8'(vb));
        cpu_write(16'hf000, 8'(ga));
        cpu_write(16'hf001, 8'(gb));
        wait_samples(2);
        s        = va * 8 * ga + vb * 8 * gb;
        exp_snd  = sat16(s);
        exp_peak = s > 32767 || s < -32768;
        if (snd !== exp_snd) report_mismatch("snd", 16'(snd), 16'(exp_snd));
        if (peak !== exp_peak) report_mismatch("peak", 16'(peak), 16'(exp_peak));
        cpu_read(16'hf000, data);
        if (data !== 8'(ga)) report_mismatch("cpu_din", 16'(data), 16'(ga));
        cpu_read(16'hf001, data);
        if (data !== 8'(gb)) report_mismatch("cpu_din", 16'(data), 16'(gb));
        // Full scale clips
        psg_write(PSG_VOL_A, 8'h0f);
        psg_write(PSG_VOL_B, 8'h0f);
        cpu_write(16'hf000, 8'hff);
        cpu_write(16'hf001, 8'hff);
        wait_samples(2);
        if (snd !== 16'sd32767) report_mismatch("snd", 16'(snd), 16'h7fff);
        if (peak !== 1'b1) report_mismatch("peak", 16'(peak), 16'h1);
        end_test("mixer_gains", first);
    endtask

    initial begin
        int i;
        void'($urandom(32'h8a2c1336));
        rst          = 1'b1;
        vblank_n     = 1'b1;
        addr         = 16'h0000;
        cpu_dout     = 8'h00;
        mreq         = 1'b0;
        rd           = 1'b0;
        wr           = 1'b0;
        iorq         = 1'b0;
        start_button = 2'b11;
        coin_input   = 2'b11;
        joystick1    = 7'h7f;
        joystick2    = 7'h7f;
        service      = 1'b1;
        dipsw        = 16'hffff;
        rom_dly      = 0;
        errors       = 0;
        tests        = 0;
        failed       = 0;
        timed_out    = 1'b0;
        bank_val     = 3'd0;
        for (i = 0; i < 2**RAM_AW; i++) begin
            ram_mem[i] = 8'(i) ^ 8'(i >> 8);
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        rom_banking();
        if (!timed_out) ram_access();
        if (!timed_out) cabinet_reads();
        if (!timed_out) vblank_irq();
        if (!timed_out) mixer_gains();
        $display("tests run %0d, tests failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/kiwi_snd_pkg.sv
verilog/snd_dev_if.sv
verilog/snd_bus_ctrl.sv
verilog/snd_rom_bank.sv
verilog/cab_inputs.sv
verilog/snd_psg.sv
verilog/snd_mixer.sv
verilog/kiwi_snd_top.sv
bench/kiwi_snd_chk.sv
bench/kiwi_snd_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the sound board testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module kiwi_snd_tb \
    --Mdir obj_dir \
    -f sources.f

./obj_dir/Vkiwi_snd_tb | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
